// File: saturn_bus_pkg.sv
// Saturn nibble bus definitions
package saturn_bus_pkg;

    localparam int PHASES       = 4;    // Clocks per bus tick.
    localparam int ADDR_NIBBLES = 5;    // Address nibbles after a load command.

    // Bus command codes. Codes above LOAD_DP are ignored by the devices.
    typedef enum logic [3:0] {
        PC_READ  = 4'h0,
        PC_WRITE = 4'h1,
        DP_READ  = 4'h2,
        DP_WRITE = 4'h3,
        LOAD_PC  = 4'h4,
        LOAD_DP  = 4'h5
    } bus_cmd_e;

    // One bus nibble, a command on a command tick or raw data otherwise.
    typedef union packed {
        bus_cmd_e   cmd;                // Valid when is_data is low.
        logic [3:0] data;               // Valid when is_data is high.
    } bus_nibble_u;

    // Word sent from the controller to every device.
    typedef struct packed {
        logic        is_data;           // Low marks a command tick.
        bus_nibble_u nib;
    } bus_word_t;

    // Read return of one device.
    typedef struct packed {
        logic       drive;              // Device owns the nibble.
        logic [3:0] nib;
    } dev_out_t;

    // Host request, nibble k of wdata goes to addr + k.
    typedef struct packed {
        logic        write;
        logic        use_dp;            // Transfer through DP, else PC.
        logic [19:0] addr;
        logic [3:0]  len;               // Nibble count minus one.
        logic [63:0] wdata;
    } host_req_t;

    // Host response, unused rdata nibbles are zero.
    typedef struct packed {
        logic [63:0] rdata;
        logic        hit;               // Some device drove a read nibble.
    } host_rsp_t;

endpackage

// File: saturn_bus_ptr.sv
// Saturn bus pointer tracker
`timescale 1ns/10ps

module saturn_bus_ptr (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_bus_clk_en,
    input  saturn_bus_pkg::bus_word_t i_bus,
    output logic [19:0]               o_pc,
    output logic [19:0]               o_dp,
    output saturn_bus_pkg::bus_cmd_e  o_mode
);
    import saturn_bus_pkg::*;

    localparam logic [2:0] LAST_POS = 3'(ADDR_NIBBLES - 1);

    logic [2:0] addr_pos;               // Next address nibble slot.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc     <= 20'h0;
            o_dp     <= 20'h0;
            o_mode   <= PC_READ;
            addr_pos <= 3'h0;
        end else if (i_bus_clk_en) begin
            if (!i_bus.is_data) begin
                case (i_bus.nib.cmd)
                    PC_READ, PC_WRITE, DP_READ, DP_WRITE: begin
                        o_mode <= i_bus.nib.cmd;
                    end
                    LOAD_PC, LOAD_DP: begin
                        o_mode   <= i_bus.nib.cmd;
                        addr_pos <= 3'h0;       // Restart the address.
                    end
                    default: begin
                    end
                endcase
            end else begin
                case (o_mode)
                    PC_READ, PC_WRITE: o_pc <= o_pc + 20'h1;
                    DP_READ, DP_WRITE: o_dp <= o_dp + 20'h1;
                    LOAD_PC: begin
                        o_pc[addr_pos*4 +: 4] <= i_bus.nib.data;  // LSN first.
                        addr_pos              <= addr_pos + 3'h1;
                        if (addr_pos == LAST_POS) begin
                            o_mode <= PC_READ;  // Auto switch.
                        end
                    end
                    LOAD_DP: begin
                        o_dp[addr_pos*4 +: 4] <= i_bus.nib.data;
                        addr_pos              <= addr_pos + 3'h1;
                        if (addr_pos == LAST_POS) begin
                            o_mode <= DP_READ;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: saturn_bus_rom.sv
// Saturn bus ROM device
`timescale 1ns/10ps

module saturn_bus_rom #(
    parameter int ROM_ADDR_BITS = 6
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_bus_clk_en,
    input  saturn_bus_pkg::bus_word_t i_bus,
    output saturn_bus_pkg::dev_out_t  o_dev
);
    import saturn_bus_pkg::*;

    logic [3:0]  mem [0:(1 << ROM_ADDR_BITS) - 1];
    logic [19:0] pc;
    logic [19:0] dp;
    logic [19:0] ptr;
    bus_cmd_e    mode;
    logic        is_read;
    logic        in_window;
    logic        drive_q;
    logic [3:0]  nib_q;

    initial $readmemh("rom_image.hex", mem);

    saturn_bus_ptr u_ptr (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (i_bus_clk_en),
        .i_bus        (i_bus),
        .o_pc         (pc),
        .o_dp         (dp),
        .o_mode       (mode)
    );

    assign ptr       = (mode == DP_READ) ? dp : pc;
    assign is_read   = (mode == PC_READ) || (mode == DP_READ);
    assign in_window = (ptr[19:ROM_ADDR_BITS] == '0);    // Window starts at zero.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            drive_q <= 1'b0;
        end else if (i_bus_clk_en) begin
            drive_q <= i_bus.is_data && is_read && in_window;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_clk_en) begin
            nib_q <= mem[ptr[ROM_ADDR_BITS-1:0]];
        end
    end

    assign o_dev = {drive_q, nib_q};

endmodule

// File: saturn_bus_ram.sv
// Saturn bus RAM device
`timescale 1ns/10ps

module saturn_bus_ram #(
    parameter int          RAM_ADDR_BITS = 6,
    parameter logic [19:0] RAM_BASE      = 20'h80000
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_bus_clk_en,
    input  saturn_bus_pkg::bus_word_t i_bus,
    output saturn_bus_pkg::dev_out_t  o_dev
);
    import saturn_bus_pkg::*;

    localparam int RAM_DEPTH = 1 << RAM_ADDR_BITS;

    logic [3:0]  mem [0:RAM_DEPTH-1];
    logic [19:0] pc;
    logic [19:0] dp;
    logic [19:0] ptr;
    logic [19:0] offset;
    bus_cmd_e    mode;
    logic        is_read;
    logic        is_write;
    logic        in_window;
    logic        drive_q;
    logic [3:0]  nib_q;

    saturn_bus_ptr u_ptr (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (i_bus_clk_en),
        .i_bus        (i_bus),
        .o_pc         (pc),
        .o_dp         (dp),
        .o_mode       (mode)
    );

    assign ptr       = ((mode == DP_READ) || (mode == DP_WRITE)) ? dp : pc;
    assign is_read   = (mode == PC_READ) || (mode == DP_READ);
    assign is_write  = (mode == PC_WRITE) || (mode == DP_WRITE);
    assign offset    = ptr - RAM_BASE;                      // Wraps below the base.
    assign in_window = (offset[19:RAM_ADDR_BITS] == '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            drive_q <= 1'b0;
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem[i] <= 4'h0;
            end
        end else if (i_bus_clk_en) begin
            drive_q <= i_bus.is_data && is_read && in_window;
            if (i_bus.is_data && is_write && in_window) begin
                mem[offset[RAM_ADDR_BITS-1:0]] <= i_bus.nib.data;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_clk_en) begin
            nib_q <= mem[offset[RAM_ADDR_BITS-1:0]];
        end
    end

    assign o_dev = {drive_q, nib_q};

endmodule

// File: saturn_bus_ctrl.sv
// Saturn bus master sequencer
`timescale 1ns/10ps

module saturn_bus_ctrl (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_req_valid,
    input  saturn_bus_pkg::host_req_t i_req,
    input  saturn_bus_pkg::dev_out_t  i_rom_dev,
    input  saturn_bus_pkg::dev_out_t  i_ram_dev,
    output logic                      o_busy,
    output logic                      o_rsp_valid,
    output logic                      o_bus_clk_en,
    output saturn_bus_pkg::bus_word_t o_bus,
    output saturn_bus_pkg::host_rsp_t o_rsp
);
    import saturn_bus_pkg::*;

    localparam int                    PHASE_BITS = $clog2(PHASES);
    localparam logic [PHASE_BITS-1:0] LAST_PHASE = PHASE_BITS'(PHASES - 1);
    localparam logic [3:0]            LAST_ADDR  = 4'(ADDR_NIBBLES - 1);
    localparam bus_word_t             IDLE_WORD  = {1'b0, 4'hF};   // Unused command code.

    typedef enum logic [2:0] {IDLE, CMD, ADDR, WCMD, DATA, DONE} state_e;

    state_e                state;
    logic [PHASE_BITS-1:0] phase;
    logic [3:0]            cnt;             // Index of the nibble on the bus.
    logic [3:0]            next_cnt;
    logic [3:0]            addr_nib;
    logic [3:0]            wdata_nib;
    host_req_t             req_q;
    logic                  accept;
    logic                  sample_pend;     // Device return valid this clock.
    logic                  hit_acc;
    logic [63:0]           rdata_acc;
    logic [3:0]            merged_nib;
    logic                  merged_drive;

    function automatic bus_word_t cmd_word(input bus_cmd_e cmd);
        bus_word_t w;
        w.is_data = 1'b0;
        w.nib.cmd = cmd;
        return w;
    endfunction

    function automatic bus_word_t data_word(input logic [3:0] nib);
        bus_word_t w;
        w.is_data  = 1'b1;
        w.nib.data = nib;
        return w;
    endfunction

    assign accept       = i_req_valid && !o_busy;
    assign next_cnt     = cnt + 4'h1;
    assign addr_nib     = 4'(req_q.addr >> {next_cnt, 2'b00});
    assign wdata_nib    = 4'(req_q.wdata >> {next_cnt, 2'b00});
    assign merged_nib   = (i_rom_dev.drive ? i_rom_dev.nib : 4'h0) |
                          (i_ram_dev.drive ? i_ram_dev.nib : 4'h0);
    assign merged_drive = i_rom_dev.drive | i_ram_dev.drive;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase        <= '0;
            o_bus_clk_en <= 1'b0;
        end else begin
            phase        <= (phase == LAST_PHASE) ? '0 : phase + 1'b1;
            o_bus_clk_en <= (phase == LAST_PHASE);  // One pulse per bus cycle.
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= IDLE;
            cnt         <= 4'h0;
            o_busy      <= 1'b0;
            o_rsp_valid <= 1'b0;
            o_bus       <= IDLE_WORD;
            sample_pend <= 1'b0;
            hit_acc     <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            sample_pend <= 1'b0;
            if (accept) begin
                o_busy  <= 1'b1;
                hit_acc <= 1'b0;
            end
            if (sample_pend) begin
                hit_acc <= hit_acc | merged_drive;
            end
            case (state)
                IDLE: if (o_bus_clk_en && o_busy) begin
                    o_bus <= cmd_word(req_q.use_dp ? LOAD_DP : LOAD_PC);
                    state <= CMD;
                end
                CMD: if (o_bus_clk_en) begin
                    o_bus <= data_word(req_q.addr[3:0]);
                    cnt   <= 4'h0;
                    state <= ADDR;
                end
                ADDR: if (o_bus_clk_en) begin
                    if (cnt != LAST_ADDR) begin
                        o_bus <= data_word(addr_nib);
                        cnt   <= next_cnt;
                    end else if (req_q.write) begin
                        o_bus <= cmd_word(req_q.use_dp ? DP_WRITE : PC_WRITE);
                        state <= WCMD;
                    end else begin
                        o_bus <= data_word(4'h0);   // Devices drive the bus.
                        cnt   <= 4'h0;
                        state <= DATA;
                    end
                end
                WCMD: if (o_bus_clk_en) begin
                    o_bus <= data_word(req_q.wdata[3:0]);
                    cnt   <= 4'h0;
                    state <= DATA;
                end
                DATA: if (o_bus_clk_en) begin
                    sample_pend <= !req_q.write;
                    if (cnt == req_q.len) begin
                        o_bus <= IDLE_WORD;
                        state <= DONE;
                    end else begin
                        o_bus <= data_word(req_q.write ? wdata_nib : 4'h0);
                        cnt   <= next_cnt;
                    end
                end
                DONE: if (!sample_pend) begin
                    o_rsp_valid <= 1'b1;        // Last read nibble is in.
                    o_busy      <= 1'b0;
                    state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q     <= i_req;
            rdata_acc <= 64'h0;
        end else if (sample_pend) begin
            rdata_acc <= {merged_nib, rdata_acc[63:4]};   // Nibbles enter at the top.
        end
        if (state == DONE && !sample_pend) begin
            o_rsp.rdata <= rdata_acc >> {4'd15 - req_q.len, 2'b00};
            o_rsp.hit   <= hit_acc;
        end
    end

endmodule

// File: saturn_bus_top.sv
// Saturn nibble bus subsystem
`timescale 1ns/10ps

module saturn_bus_top #(
    parameter int          ROM_ADDR_BITS = 6,
    parameter int          RAM_ADDR_BITS = 6,
    parameter logic [19:0] RAM_BASE      = 20'h80000
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_req_valid,
    input  saturn_bus_pkg::host_req_t i_req,
    output logic                      o_busy,
    output logic                      o_rsp_valid,
    output saturn_bus_pkg::host_rsp_t o_rsp
);
    import saturn_bus_pkg::*;

    logic      bus_clk_en;
    bus_word_t bus;                     // Shared by both devices.
    dev_out_t  rom_dev;
    dev_out_t  ram_dev;

    saturn_bus_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_rom_dev    (rom_dev),
        .i_ram_dev    (ram_dev),
        .o_busy       (o_busy),
        .o_rsp_valid  (o_rsp_valid),
        .o_bus_clk_en (bus_clk_en),
        .o_bus        (bus),
        .o_rsp        (o_rsp)
    );

    saturn_bus_rom #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) u_rom (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (bus_clk_en),
        .i_bus        (bus),
        .o_dev        (rom_dev)
    );

    saturn_bus_ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .RAM_BASE      (RAM_BASE)
    ) u_ram (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_clk_en (bus_clk_en),
        .i_bus        (bus),
        .o_dev        (ram_dev)
    );

endmodule

// File: saturn_bus_checker.sv
// Saturn bus response checker
`timescale 1ns/10ps

module saturn_bus_checker (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_exp_valid,
    input  saturn_bus_pkg::host_rsp_t i_exp,
    input  logic                      i_rsp_valid,
    input  saturn_bus_pkg::host_rsp_t i_rsp,
    input  logic                      i_end_check,
    output int                        o_error_count
);
    import saturn_bus_pkg::*;

    host_rsp_t exp_q[$];                // Responses still owed by the DUT.
    host_rsp_t exp;
    int        checked;

    // Inputs are driven on the falling edge, so the rising edge sees settled values.
    always @(posedge i_clk) begin
        if (i_reset) begin
            o_error_count = 0;
            checked       = 0;
            exp_q.delete();
        end else begin
            if (i_rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A response arrived at %0t ns with no request outstanding",
                             $time);
                    o_error_count = o_error_count + 1;
                end else begin
                    exp     = exp_q.pop_front();
                    checked = checked + 1;
                    if (i_rsp !== exp) begin
                        $display("Error %0t ns: response %0d rdata %h hit %b, expected %h hit %b",
                                 $time, checked, i_rsp.rdata, i_rsp.hit, exp.rdata, exp.hit);
                        o_error_count = o_error_count + 1;
                    end
                end
            end
            if (i_exp_valid) begin
                exp_q.push_back(i_exp);     // Queued at acceptance.
            end
            if (i_end_check) begin
                if (exp_q.size() != 0) begin
                    $display("%0d accepted requests never got a response", exp_q.size());
                    o_error_count = o_error_count + exp_q.size();
                end
                $display("Checker compared %0d responses", checked);
            end
        end
    end

endmodule

// File: tb_saturn_bus.sv
// Saturn bus testbench
`timescale 1ns/10ps

module tb_saturn_bus;
    import saturn_bus_pkg::*;

    localparam int          ROM_ADDR_BITS = 6;
    localparam int          RAM_ADDR_BITS = 6;
    localparam logic [19:0] RAM_BASE      = 20'h80000;
    localparam int          CLK_PERIOD    = 4;
    localparam int          SEED          = 64647;
    localparam int          NUM_REQS      = 60;     // Requests issued by the whole run.
    localparam int          MARGIN_CLKS   = 1000;   // Idle stretches and drain time.

    logic      clk;
    logic      reset;
    logic      req_valid;
    host_req_t req;
    logic      busy;
    logic      rsp_valid;
    host_rsp_t rsp;
    logic      exp_valid;
    host_rsp_t exp_rsp;
    logic      end_check;
    int        checker_errors;
    int        tb_errors;
    int        num_issued;

    logic [3:0] rom_model [0:(1 << ROM_ADDR_BITS) - 1];
    logic [3:0] ram_model [0:(1 << RAM_ADDR_BITS) - 1];

    saturn_bus_top #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS),
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .RAM_BASE      (RAM_BASE)
    ) u_saturn_bus_top (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_busy      (busy),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp)
    );

    saturn_bus_checker u_checker (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_exp_valid   (exp_valid),
        .i_exp         (exp_rsp),
        .i_rsp_valid   (rsp_valid),
        .i_rsp         (rsp),
        .i_end_check   (end_check),
        .o_error_count (checker_errors)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Expected read from the ROM at address zero and the RAM at its base.
    function automatic host_rsp_t ref_read(input logic [19:0] addr, input logic [3:0] len);
        host_rsp_t   res;
        logic [19:0] a;
        logic [19:0] off;
        res = '0;
        for (int k = 0; k <= int'(len); k++) begin
            a   = addr + 20'(k);            // Pointer wraps at 20 bits.
            off = a - RAM_BASE;
            if (a < 20'(1 << ROM_ADDR_BITS)) begin
                res.rdata[k*4 +: 4] = rom_model[a[ROM_ADDR_BITS-1:0]];
                res.hit             = 1'b1;
            end else if (off < 20'(1 << RAM_ADDR_BITS)) begin
                res.rdata[k*4 +: 4] = ram_model[off[RAM_ADDR_BITS-1:0]];
                res.hit             = 1'b1;
            end
        end
        return res;
    endfunction

    task automatic write_model(input logic [19:0] addr, input logic [3:0] len,
                               input logic [63:0] wdata);
        logic [19:0] off;
        for (int k = 0; k <= int'(len); k++) begin
            off = addr + 20'(k) - RAM_BASE;
            if (off < 20'(1 << RAM_ADDR_BITS)) begin
                ram_model[off[RAM_ADDR_BITS-1:0]] = wdata[k*4 +: 4];
            end
        end
    endtask

    task automatic send_req(input logic wr, input logic dp, input logic [19:0] addr,
                            input logic [3:0] len, input logic [63:0] wdata);
        while (busy) @(negedge clk);
        if (wr) begin
            write_model(addr, len, wdata);
            exp_rsp = '0;                   // Writes return nothing.
        end else begin
            exp_rsp = ref_read(addr, len);
        end
        req       = {wr, dp, addr, len, wdata};
        req_valid = 1'b1;
        exp_valid = 1'b1;
        @(negedge clk);
        req_valid  = 1'b0;
        exp_valid  = 1'b0;
        num_issued = num_issued + 1;
    endtask

    task automatic run_req(input logic wr, input logic dp, input logic [19:0] addr,
                           input logic [3:0] len, input logic [63:0] wdata);
        send_req(wr, dp, addr, len, wdata);
        while (!rsp_valid) @(negedge clk);  // Next request goes out right after.
        if (busy) begin
            $display("Error %0t ns: busy still high on the response clock", $time);
            tb_errors = tb_errors + 1;
        end
    endtask

    initial begin
        logic [3:0]  len;
        logic [19:0] addr;
        int          total;
        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        exp_valid  = 1'b0;
        exp_rsp    = '0;
        end_check  = 1'b0;
        tb_errors  = 0;
        num_issued = 0;
        void'($urandom(SEED));
        $readmemh("rom_image.hex", rom_model);
        for (int i = 0; i < (1 << RAM_ADDR_BITS); i++) begin
            ram_model[i] = 4'h0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        repeat (20) begin
            @(negedge clk);
            if (busy || rsp_valid) begin
                $display("Error %0t ns: busy or rsp_valid high with no request", $time);
                tb_errors = tb_errors + 1;
            end
        end

        for (int i = 0; i < 16; i++) begin
            len  = 4'($urandom_range(0, 15));
            addr = 20'($urandom_range(0, 63 - int'(len)));     // Fully inside the ROM.
            run_req(1'b0, i[0], addr, len, 64'h0);
        end

        for (int i = 0; i < 8; i++) begin
            len  = 4'($urandom_range(0, 15));
            addr = RAM_BASE + 20'($urandom_range(0, 48));
            run_req(1'b1, i[0], addr, len, {$urandom(), $urandom()});
            run_req(1'b0, !i[0], addr, len, 64'h0);     // Read back through the other pointer.
        end

        for (int i = 0; i < 4; i++) begin
            addr = 20'h10000 + 20'($urandom_range(0, 20'h5FFFF));
            run_req(1'b0, i[0], addr, 4'($urandom_range(0, 15)), 64'h0);
        end
        run_req(1'b0, 1'b0, 20'h0003C, 4'd7, 64'h0);            // Runs off the ROM end.
        run_req(1'b0, 1'b1, RAM_BASE + 20'h3A, 4'd11, 64'h0);   // Runs off the RAM end.

        for (int i = 0; i < 3; i++) begin
            addr = 20'($urandom_range(0, 48));
            run_req(1'b1, i[0], addr, 4'd15, {$urandom(), $urandom()});
            run_req(1'b0, i[0], addr, 4'd15, 64'h0);
        end
        for (int i = 0; i < 2; i++) begin
            addr = 20'h20000 + 20'($urandom_range(0, 20'hFFFF));
            run_req(1'b1, i[0], addr, 4'd15, {$urandom(), $urandom()});
            run_req(1'b0, !i[0], addr, 4'd15, 64'h0);
        end
        run_req(1'b1, 1'b1, RAM_BASE - 20'h4, 4'd7, {$urandom(), $urandom()});
        run_req(1'b0, 1'b0, RAM_BASE - 20'h4, 4'd7, 64'h0);   // Upper half lands in RAM.

        for (int i = 0; i < 8; i++) begin
            len = 4'($urandom_range(0, 15));
            case ($urandom_range(0, 2))
                0: addr = 20'($urandom_range(0, 63));
                1: addr = RAM_BASE + 20'($urandom_range(0, 63));
                default: addr = 20'($urandom());
            endcase
            run_req(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), addr, len,
                    {$urandom(), $urandom()});
        end

        send_req(1'b0, 1'b0, 20'h00010, 4'd7, 64'h0);
        if (!busy) begin
            $display("Error %0t ns: busy low after a request was accepted", $time);
            tb_errors = tb_errors + 1;
        end
        req       = {1'b1, 1'b0, RAM_BASE, 4'd15, 64'hFFFF_FFFF_FFFF_FFFF};
        req_valid = 1'b1;                   // Dropped while busy.
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        repeat (150) @(negedge clk);
        run_req(1'b0, 1'b1, RAM_BASE, 4'd15, 64'h0);

        repeat (50) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        total = tb_errors + checker_errors;
        $display("Run done: %0d requests, %0d errors (%0d checker, %0d stimulus)",
                 num_issued, total, checker_errors, tb_errors);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Worst case is well under 30 bus ticks per request.
    initial begin
        #(CLK_PERIOD * (NUM_REQS * PHASES * 30 + MARGIN_CLKS));
        $display("Timeout: the run did not finish within the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: rom_image.hex
// ROM image, one hex nibble per line, address 0 first
2
4
3
F
6
A
8
8
8
5
A
3
0
8
D
3
1
3
1
9
8
A
2
E
0
3
7
0
7
3
4
4
A
4
0
9
3
8
2
2
2
9
9
F
3
1
D
0
0
8
2
E
F
A
9
8
E
C
4
E
6
C
8
9

// File: saturn_bus.f
saturn_bus_pkg.sv
saturn_bus_ptr.sv
saturn_bus_rom.sv
saturn_bus_ram.sv
saturn_bus_ctrl.sv
saturn_bus_top.sv
saturn_bus_checker.sv
tb_saturn_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Saturn bus testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_saturn_bus \
    -f saturn_bus.f -o tb_saturn_bus
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_saturn_bus > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
